/* eeprom_proto_pkg.sv */
package eeprom_proto_pkg;

    // 24C16 device type, upper nibble of every control byte
    localparam logic [3:0] dev_code = 4'b1010;

    localparam logic rw_write = 1'b0;
    localparam logic rw_read  = 1'b1;

    typedef struct packed {
        logic [3:0] dev;    // device type code
        logic [2:0] block;  // addr[10:8], selects one of eight 256-byte blocks
        logic       rw;
    } ctrl_fields_t;

    // control byte as seen on the wire vs. as decoded
    typedef union packed {
        logic [7:0]   raw;
        ctrl_fields_t f;
    } ctrl_byte_t;

endpackage

/* eeprom_ctl_pkg.sv */
package eeprom_ctl_pkg;

    // bit engine commands
    typedef enum logic [2:0] {
        cmd_start,
        cmd_stop,
        cmd_write,
        cmd_read_ack,
        cmd_read_nack
    } cmd_t;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_ctrl_w,
        st_addr,
        st_data_w,
        st_rstart,  // repeated start of a random read
        st_ctrl_r,
        st_data_r,
        st_stop
    } seq_state_t;

    localparam logic [7:0] scl_half_default = 8'd4;

endpackage

/* eeprom_cfg.sv */
`timescale 1ns/1ns

module eeprom_cfg
    import eeprom_ctl_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       cfg_wr,
    input  logic [7:0] cfg_wdata,
    input  logic       busy,
    output logic [7:0] scl_half
);

    // half period is scl_half+1 CLK cycles
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_half <= scl_half_default;
        end
        else if (cfg_wr && !busy)
        begin
            scl_half <= cfg_wdata; // ignored mid-transfer
        end
    end

endmodule

/* i2c_bit_engine.sv */
`timescale 1ns/1ns

module i2c_bit_engine
    import eeprom_ctl_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic [7:0] scl_half,
    input  logic       cmd_go,
    input  cmd_t       cmd,
    input  logic [7:0] tx_byte,
    output logic       cmd_done,
    output logic [7:0] rx_byte,
    output logic       ack_ok,
    output logic       scl,
    output logic       sda_oe,
    input  logic       sda_in
);

    logic       active;
    logic [7:0] cnt;      // half-period down counter
    logic [4:0] ph;       // current half-period slot
    cmd_t       cmd_q;
    logic [7:0] tx_q;
    logic       launch;
    logic       tick;
    logic       is_read;
    cmd_t       cmd_s;
    logic [7:0] tx_s;
    logic [4:0] slot;     // slot about to begin
    logic [4:0] last;
    logic       scl_n;
    logic       oe_n;

    assign launch  = cmd_go && !active;
    assign tick    = active && (cnt == 8'd0);
    assign is_read = (cmd_q == cmd_read_ack) || (cmd_q == cmd_read_nack);
    assign cmd_s   = launch ? cmd : cmd_q;
    assign tx_s    = launch ? tx_byte : tx_q;
    assign slot    = launch ? 5'd0 : ph + 5'd1;

    always_comb
    begin
        case (cmd_q)
            cmd_start: last = 5'd3;
            cmd_stop:  last = 5'd2;
            default:   last = 5'd17; // 8 data bits + ack, two slots each
        endcase
    end

    // bus levels for the next slot
    always_comb
    begin
        scl_n = slot[0];
        oe_n  = 1'b0;
        case (cmd_s)
            cmd_start:
            begin
                scl_n = (slot == 5'd0) ? scl : (slot != 5'd3); // keep level, release sda first
                oe_n  = slot[1];                               // sda falls with scl high
            end
            cmd_stop:
            begin
                scl_n = (slot != 5'd0);
                oe_n  = (slot != 5'd2); // sda rises with scl high
            end
            cmd_write: oe_n = (slot < 5'd16) && !tx_s[3'd7 - slot[3:1]];
            default:   oe_n = (slot >= 5'd16) && (cmd_s == cmd_read_ack);
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            cnt      <= 8'd0;
            ph       <= 5'd0;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
            cmd_done <= 1'b0;
            ack_ok   <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (launch)
            begin
                active <= 1'b1;
                cnt    <= scl_half;
                ph     <= 5'd0;
                scl    <= scl_n;
                sda_oe <= oe_n;
            end
            else if (tick)
            begin
                cnt <= scl_half;
                if (cmd_q == cmd_write && ph == 5'd17)
                begin
                    ack_ok <= !sda_in; // slave holds sda low on ack
                end
                if (ph == last)
                begin
                    active   <= 1'b0;
                    cmd_done <= 1'b1;
                    if (last == 5'd17)
                    begin
                        scl <= 1'b0; // byte commands leave scl low
                    end
                end
                else
                begin
                    ph     <= slot;
                    scl    <= scl_n;
                    sda_oe <= oe_n;
                end
            end
            else if (active)
            begin
                cnt <= cnt - 8'd1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (launch)
        begin
            cmd_q <= cmd;
            tx_q  <= tx_byte;
        end
        if (tick && is_read && ph[0] && !ph[4])
        begin
            rx_byte <= {rx_byte[6:0], sda_in}; // msb first, end of each scl high
        end
    end

endmodule

/* eeprom_seq.sv */
`timescale 1ns/1ns

module eeprom_seq
    import eeprom_proto_pkg::*;
    import eeprom_ctl_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    output logic        busy,
    output logic        done,
    output logic [7:0]  rdata,
    output logic        nack_err,
    output logic        cmd_go,
    output cmd_t        cmd,
    output logic [7:0]  tx_byte,
    input  logic        cmd_done,
    input  logic [7:0]  rx_byte,
    input  logic        ack_ok
);

    seq_state_t  state;
    seq_state_t  nxt;      // successor when the slave acked
    logic        pending;  // command in flight
    logic        accept;
    logic        issue;
    logic        is_rd;
    logic [10:0] addr_q;
    logic [7:0]  wdata_q;
    ctrl_byte_t  ctrl;
    cmd_t        cmd_n;
    logic [7:0]  tx_n;

    assign accept = (state == st_idle) && (wr || rd);
    assign issue  = (state != st_idle) && !pending;

    always_comb
    begin
        ctrl.f.dev   = dev_code;
        ctrl.f.block = addr_q[10:8];
        ctrl.f.rw    = (state == st_ctrl_r) ? rw_read : rw_write;
    end

    always_comb
    begin
        cmd_n = cmd_write;
        tx_n  = ctrl.raw;
        case (state)
            st_start, st_rstart: cmd_n = cmd_start;
            st_addr:             tx_n  = addr_q[7:0];
            st_data_w:           tx_n  = wdata_q;
            st_data_r:           cmd_n = cmd_read_nack; // single byte, no ack
            st_stop:             cmd_n = cmd_stop;
            default:             cmd_n = cmd_write;
        endcase
    end

    always_comb
    begin
        case (state)
            st_start:  nxt = st_ctrl_w;
            st_ctrl_w: nxt = st_addr;
            st_addr:   nxt = is_rd ? st_rstart : st_data_w;
            st_rstart: nxt = st_ctrl_r;
            st_ctrl_r: nxt = st_data_r;
            default:   nxt = st_stop;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= st_idle;
            pending  <= 1'b0;
            cmd_go   <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            nack_err <= 1'b0;
        end
        else
        begin
            cmd_go <= 1'b0;
            done   <= 1'b0;
            if (accept)
            begin
                busy     <= 1'b1;
                nack_err <= 1'b0;
                state    <= st_start;
            end
            else if (issue)
            begin
                cmd_go  <= 1'b1;
                pending <= 1'b1;
            end
            else if (pending && cmd_done)
            begin
                pending <= 1'b0;
                if (cmd == cmd_write && !ack_ok)
                begin
                    nack_err <= 1'b1;
                    state    <= st_stop; // abort, still release the bus
                end
                else if (state == st_stop)
                begin
                    state <= st_idle;
                    busy  <= 1'b0; // drops as done rises
                    done  <= 1'b1;
                end
                else
                begin
                    state <= nxt;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            is_rd   <= !wr; // wr wins
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (issue)
        begin
            cmd     <= cmd_n;
            tx_byte <= tx_n;
        end
        if (pending && cmd_done && state == st_data_r)
        begin
            rdata <= rx_byte;
        end
    end

endmodule

/* eeprom_ctrl_top.sv */
`timescale 1ns/1ns

module eeprom_ctrl_top
    import eeprom_ctl_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    input  logic        cfg_wr,
    input  logic [7:0]  cfg_wdata,
    output logic        busy,
    output logic        done,
    output logic [7:0]  rdata,
    output logic        nack_err,
    output logic        scl,
    output logic        sda_oe,
    input  logic        sda_in
);

    logic [7:0] scl_half;
    logic       cmd_go;
    cmd_t       cmd;
    logic [7:0] tx_byte;
    logic       cmd_done;
    logic [7:0] rx_byte;
    logic       ack_ok;

    eeprom_cfg u_cfg (
        .CLK       (CLK),
        .RESET     (RESET),
        .cfg_wr    (cfg_wr),
        .cfg_wdata (cfg_wdata),
        .busy      (busy),
        .scl_half  (scl_half)
    );

    eeprom_seq u_seq (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .busy     (busy),
        .done     (done),
        .rdata    (rdata),
        .nack_err (nack_err),
        .cmd_go   (cmd_go),
        .cmd      (cmd),
        .tx_byte  (tx_byte),
        .cmd_done (cmd_done),
        .rx_byte  (rx_byte),
        .ack_ok   (ack_ok)
    );

    i2c_bit_engine u_bit (
        .CLK      (CLK),
        .RESET    (RESET),
        .scl_half (scl_half),
        .cmd_go   (cmd_go),
        .cmd      (cmd),
        .tx_byte  (tx_byte),
        .cmd_done (cmd_done),
        .rx_byte  (rx_byte),
        .ack_ok   (ack_ok),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

endmodule

/* eeprom_model.sv */
`timescale 1ns/1ns

module eeprom_model
    import eeprom_proto_pkg::*;
(
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic force_nack,
    output logic sda_oe
);

    typedef enum logic [2:0] {m_idle, m_rx, m_ack, m_tx, m_tx_ack} mstate_t;

    logic [7:0]  mem [0:2047];
    mstate_t     st;
    logic        scl_q;
    logic        sda_q;
    logic [3:0]  bits;
    logic [7:0]  sh;
    logic [1:0]  idx;      // byte number since start
    logic [2:0]  block;
    logic [7:0]  word;
    logic        reading;
    ctrl_byte_t  rx_ctrl;
    logic        rise;
    logic        fall;
    logic        start_c;
    logic        stop_c;

    assign rise    = scl && !scl_q;
    assign fall    = !scl && scl_q;
    assign start_c = scl && scl_q && sda_q && !sda;
    assign stop_c  = scl && scl_q && !sda_q && sda;

    always_comb
    begin
        rx_ctrl.raw = sh;
    end

    initial
    begin
        for (int i = 0; i < 2048; i++)
        begin
            mem[i] = 8'(i * 37 + (i >> 8)); // whole address in the fill
        end
    end

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            st     <= m_idle;
            sda_oe <= 1'b0;
            bits   <= 4'd0;
            idx    <= 2'd0;
        end
        else if (start_c)
        begin
            st     <= m_rx;
            bits   <= 4'd0;
            idx    <= 2'd0;
            sda_oe <= 1'b0;
        end
        else if (stop_c)
        begin
            st     <= m_idle;
            sda_oe <= 1'b0;
        end
        else
        begin
            case (st)
                m_rx:
                begin
                    if (rise)
                    begin
                        sh   <= {sh[6:0], sda};
                        bits <= bits + 4'd1;
                    end
                    else if (fall && bits == 4'd8)
                    begin
                        bits <= 4'd0;
                        if (force_nack || (idx == 2'd0 && rx_ctrl.f.dev != dev_code))
                        begin
                            st <= m_idle; // no ack, wait for stop
                        end
                        else
                        begin
                            sda_oe <= 1'b1;
                            st     <= m_ack;
                            if (idx == 2'd0)
                            begin
                                block   <= rx_ctrl.f.block;
                                reading <= (rx_ctrl.f.rw == rw_read);
                            end
                            else if (idx == 2'd1)
                            begin
                                word <= sh;
                            end
                            else if (idx == 2'd2)
                            begin
                                mem[{block, word}] <= sh;
                            end
                        end
                    end
                end
                m_ack:
                begin
                    if (fall && reading)
                    begin
                        sh     <= mem[{block, word}];
                        sda_oe <= !mem[{block, word}][7];
                        bits   <= 4'd0;
                        st     <= m_tx;
                    end
                    else if (fall)
                    begin
                        sda_oe <= 1'b0;
                        idx    <= idx + 2'd1;
                        st     <= m_rx;
                    end
                end
                m_tx:
                begin
                    if (rise)
                    begin
                        bits <= bits + 4'd1;
                    end
                    else if (fall && bits == 4'd8)
                    begin
                        sda_oe <= 1'b0;
                        st     <= m_tx_ack;
                    end
                    else if (fall)
                    begin
                        sda_oe <= !sh[6];
                        sh     <= {sh[6:0], 1'b0};
                    end
                end
                m_tx_ack:
                begin
                    if (rise)
                    begin
                        st <= m_idle; // single byte read ends here
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* eeprom_bus_checker.sv */
`timescale 1ns/1ns

module eeprom_bus_checker
    import eeprom_ctl_pkg::*;
(
    input  logic CLK,
    input  logic RESET,
    input  logic active,
    input  cmd_t cmd_q,
    input  logic cmd_done,
    input  logic scl,
    input  logic sda_oe
);

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        cmd_done |=> !cmd_done)
        else $error("cmd_done longer than one cycle");

    // data changes only with scl low
    a_sda_change: assert property (@(posedge CLK) disable iff (RESET)
        (sda_oe != $past(sda_oe)) && cmd_q != cmd_start && cmd_q != cmd_stop |-> !scl)
        else $error("sda changed while scl high outside start or stop");

    a_idle_bus: assert property (@(posedge CLK) disable iff (RESET)
        !active && cmd_q == cmd_stop |-> scl && !sda_oe)
        else $error("bus not released after stop");

endmodule

bind i2c_bit_engine eeprom_bus_checker u_bus_chk (
    .CLK      (CLK),
    .RESET    (RESET),
    .active   (active),
    .cmd_q    (cmd_q),
    .cmd_done (cmd_done),
    .scl      (scl),
    .sda_oe   (sda_oe)
);

/* tb_eeprom_ctrl.sv */
`timescale 1ns/1ns

module tb_eeprom_ctrl;

    localparam int n_rows = 17;

    typedef enum logic [2:0] {op_wr, op_rd, op_cfg, op_cfg_busy, op_wr_twice} op_t;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wdata;
    logic        cfg_wr;
    logic [7:0]  cfg_wdata;
    logic        busy;
    logic        done;
    logic [7:0]  rdata;
    logic        nack_err;
    logic        scl;
    logic        dut_oe;
    logic        mdl_oe;
    logic        sda;
    logic        force_nack;
    logic        meas_clr;
    logic        scl_q;
    int          run;
    int          min_hi;
    int          min_lo;

    op_t         t_op    [n_rows];
    logic [10:0] t_addr  [n_rows];
    logic [7:0]  t_data  [n_rows];
    logic        t_fnack [n_rows];
    logic        t_nack  [n_rows];
    logic [7:0]  shadow  [0:2047];

    int          errors;
    int          checks;
    int          row_err;
    int          exp_half;

    assign sda = !(dut_oe || mdl_oe); // pulled up, open drain

    eeprom_ctrl_top uut (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .cfg_wr    (cfg_wr),
        .cfg_wdata (cfg_wdata),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .nack_err  (nack_err),
        .scl       (scl),
        .sda_oe    (dut_oe),
        .sda_in    (sda)
    );

    eeprom_model u_model (
        .CLK        (CLK),
        .RESET      (RESET),
        .scl        (scl),
        .sda        (sda),
        .force_nack (force_nack),
        .sda_oe     (mdl_oe)
    );

    initial
    begin
        CLK = 1'b0;
        forever
        begin
            #5 CLK = !CLK;
        end
    end

    // shortest scl high and low phase, in CLK cycles
    always @(posedge CLK)
    begin
        if (RESET || meas_clr)
        begin
            run    <= 1;
            min_hi <= 9999;
            min_lo <= 9999;
            scl_q  <= scl;
        end
        else if (scl == scl_q)
        begin
            run <= run + 1;
        end
        else
        begin
            if (scl_q && run < min_hi)
            begin
                min_hi <= run;
            end
            if (!scl_q && run < min_lo)
            begin
                min_lo <= run;
            end
            run   <= 1;
            scl_q <= scl;
        end
    end

    initial
    begin
        #(n_rows * 40 * 256 * 10 * 2 + 1000);
        $display("timeout: the controller did not finish the tests in time");
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check_val(input string what, input int got, input int exp);
        checks++;
        assert (got == exp)
        else
        begin
            $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
            row_err++;
        end
    endtask

    task automatic check_cond(input logic ok, input string msg);
        checks++;
        assert (ok)
        else
        begin
            $display("error at %0t ns: %s", $time, msg);
            errors++;
            row_err++;
        end
    endtask

    task automatic set_row(input int i, input op_t op, input logic [10:0] a,
                           input logic [7:0] d, input logic fn, input logic en);
        t_op[i]    = op;
        t_addr[i]  = a;
        t_data[i]  = d;
        t_fnack[i] = fn;
        t_nack[i]  = en;
    endtask

    task automatic build_table();
        logic [10:0] a0;
        logic [10:0] a1;
        logic [10:0] a2;
        logic [10:0] a3;
        logic [10:0] a4;
        logic [7:0]  d0;
        a0 = 11'($urandom);
        a1 = {a0[10:8] ^ 3'b101, a0[7:0]}; // same word, other block
        a2 = 11'($urandom);
        a3 = 11'($urandom);
        a4 = 11'($urandom);
        d0 = 8'($urandom);
        set_row(0, op_wr, a0, d0, 1'b0, 1'b0);
        set_row(1, op_rd, a0, 8'h00, 1'b0, 1'b0);
        set_row(2, op_wr, a1, ~d0, 1'b0, 1'b0);
        set_row(3, op_rd, a0, 8'h00, 1'b0, 1'b0);
        set_row(4, op_rd, a1, 8'h00, 1'b0, 1'b0);
        set_row(5, op_wr, a0, d0 ^ 8'h3c, 1'b1, 1'b1);
        set_row(6, op_rd, a0, 8'h00, 1'b0, 1'b0);
        set_row(7, op_cfg, 11'd0, 8'd2, 1'b0, 1'b0);
        set_row(8, op_wr, a2, 8'($urandom), 1'b0, 1'b0);
        set_row(9, op_rd, a2, 8'h00, 1'b0, 1'b0);
        set_row(10, op_cfg_busy, a1, 8'd9, 1'b0, 1'b0);
        set_row(11, op_cfg, 11'd0, 8'd7, 1'b0, 1'b0);
        set_row(12, op_rd, a1, 8'h00, 1'b0, 1'b0);
        set_row(13, op_wr_twice, a3, 8'($urandom), 1'b0, 1'b0);
        set_row(14, op_rd, a3, 8'h00, 1'b0, 1'b0);
        set_row(15, op_rd, a4, 8'h00, 1'b0, 1'b0);
        set_row(16, op_rd, a0, 8'h00, 1'b1, 1'b1);
    endtask

    task automatic load_cfg(input logic [7:0] v);
        @(posedge CLK);
        cfg_wr    <= 1'b1;
        cfg_wdata <= v;
        @(posedge CLK);
        cfg_wr    <= 1'b0;
    endtask

    task automatic start_xfer(input int i, input logic is_wr);
        @(posedge CLK);
        meas_clr   <= 1'b1;
        force_nack <= t_fnack[i];
        @(posedge CLK);
        meas_clr <= 1'b0;
        wr       <= is_wr;
        rd       <= !is_wr;
        addr     <= t_addr[i];
        wdata    <= t_data[i];
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic finish_xfer(input int i, input logic is_wr);
        logic busy_gap;
        busy_gap = 1'b0;
        do
        begin
            @(negedge CLK);
            if (!done && !busy)
            begin
                busy_gap = 1'b1;
            end
        end
        while (!done);
        check_cond(!busy_gap, "busy went low before done during a transfer");
        check_val("nack_err", int'(nack_err), int'(t_nack[i]));
        if (!is_wr && !t_nack[i])
        begin
            check_val("rdata", int'(rdata), int'(shadow[t_addr[i]]));
        end
        check_val("scl high phase", min_hi, exp_half + 1);
        check_val("scl low phase", min_lo, exp_half + 1);
        if (is_wr && !t_nack[i])
        begin
            shadow[t_addr[i]] = t_data[i];
        end
    endtask

    task automatic run_row(input int i);
        row_err = 0;
        case (t_op[i])
            op_cfg:
            begin
                load_cfg(t_data[i]);
                exp_half = int'(t_data[i]);
            end
            op_cfg_busy:
            begin
                start_xfer(i, 1'b0);
                repeat (3) @(posedge CLK);
                load_cfg(t_data[i]); // must not take effect
                finish_xfer(i, 1'b0);
            end
            op_wr_twice:
            begin
                start_xfer(i, 1'b1);
                @(posedge CLK);
                rd   <= 1'b1;
                addr <= ~t_addr[i];
                @(posedge CLK);
                rd <= 1'b0;
                finish_xfer(i, 1'b1);
                repeat (20)
                begin
                    @(negedge CLK);
                    check_cond(!busy && !done, "a request made while busy started a transfer");
                end
            end
            default:
            begin
                start_xfer(i, t_op[i] == op_wr);
                finish_xfer(i, t_op[i] == op_wr);
            end
        endcase
        $display("row %0d %s addr %h data %h: %s", i, t_op[i].name(), t_addr[i], t_data[i],
                 (row_err == 0) ? "ok" : "failed");
    endtask

    initial
    begin
        void'($urandom(32'h0d38_bfb8));
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = 11'd0;
        wdata      = 8'd0;
        cfg_wr     = 1'b0;
        cfg_wdata  = 8'd0;
        force_nack = 1'b0;
        meas_clr   = 1'b0;
        errors     = 0;
        checks     = 0;
        exp_half   = 4;
        for (int a = 0; a < 2048; a++)
        begin
            shadow[a] = 8'(a * 37 + (a >> 8));
        end
        build_table();
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
        row_err = 0;
        repeat (5)
        begin
            @(negedge CLK);
            check_cond(!busy && !done && scl && !dut_oe, "outputs not idle after reset");
        end
        $display("reset state: %s", (row_err == 0) ? "ok" : "failed");
        for (int i = 0; i < n_rows; i++)
        begin
            run_row(i);
        end
        $display("rows %0d, checks %0d, errors %0d", n_rows, checks, errors);
        if (errors == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* vlog.f */
eeprom_proto_pkg.sv
eeprom_ctl_pkg.sv
eeprom_cfg.sv
i2c_bit_engine.sv
eeprom_seq.sv
eeprom_ctrl_top.sv
eeprom_model.sv
eeprom_bus_checker.sv
tb_eeprom_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the EEPROM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_eeprom_ctrl \
    -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
grep -q "NO ERRORS" sim.log || exit 1
exit 0
